// File: source/fp_format_pkg.sv
// ####################
// FP number formats
// FP29i add operands are always denormal, FP16 multiply
// operands carry a hidden bit when the exponent is nonzero
// ####################
`default_nettype none

package fp_format_pkg;

	// FP29i, sign + 6b exponent + 22b mantissa
	localparam int AL_MAN_W    = 22;          // Value is man / 2^21, no hidden bit
	localparam int AL_EXP_W    = 6;
	localparam int AL_SUM_W    = AL_MAN_W + 1; // One guard bit above the mantissa
	localparam int AL_EXP_BIAS = 31;

	// FP16, sign + 5b exponent + 10b fraction
	localparam int ML_MAN_W    = 11;          // Fraction plus hidden bit
	localparam int ML_EXP_W    = 5;
	localparam int ML_EXP_BIAS = 15;

	// Leading zeros of a sum word, 0..23
	localparam int LZ_CNT_W    = 5;

	typedef logic [AL_MAN_W-1:0] al_man_t;
	typedef logic [AL_EXP_W-1:0] al_exp_t;
	typedef logic [AL_SUM_W-1:0] al_sum_t;

	typedef logic [ML_MAN_W-1:0] ml_man_t;
	typedef logic [ML_EXP_W-1:0] ml_exp_t;

	typedef logic [LZ_CNT_W-1:0] lz_cnt_t;

endpackage

`default_nettype wire

// File: source/alu_op_pkg.sv
// ####################
// ALU opcodes and sizes of the
// radix-4 Booth multiplier
// ####################
`default_nettype none

package alu_op_pkg;

	// OP_SKIP never enters from outside, the add path sets it
	typedef enum logic [1:0] {
		OP_SKIP = 2'b01, // Zero mantissa on the large exponent side
		OP_MUL  = 2'b10, // FP16 x FP16 -> FP29i
		OP_ADD  = 2'b11  // FP29i +/- FP29i
	} alu_op_e;

	// 11b multiplicand, times two fits in 12b
	localparam int PP_W     = 12;
	localparam int PP_COUNT = 6;        // 11b multiplier + two zero pad bits, 3b groups
	localparam int PSUM0_W  = PP_W + 7; // Rows 0..2 with sign extension
	localparam int PSUM1_W  = PP_W + 4; // Rows 3..5, weighted by 2^6

	typedef logic [PP_W-1:0]    pp_t;
	typedef logic [PSUM0_W-1:0] psum0_t;
	typedef logic [PSUM1_W-1:0] psum1_t;

endpackage

`default_nettype wire

// File: source/fp_alu_if.sv
// ####################
// Stage-to-stage bundles of the FP ALU
// align -> sum, Booth -> sum, sum -> normalize
// ####################
`timescale 1ns/1ps
`default_nettype none

// Aligned add operands plus the relay of exponents and signs
interface align_if import fp_format_pkg::*, alu_op_pkg::*; ();
	logic     valid;
	alu_op_e  op;       // OP_ADD becomes OP_SKIP here
	al_sum_t  lhs;      // Larger exponent mantissa
	al_sum_t  rhs;      // Shifted, inverted for subtract
	logic     add_sub;  // 1 add, 0 subtract
	al_exp_t  exp_a;
	al_exp_t  exp_b;
	logic     a_ge_b;   // exp_a >= exp_b
	logic     sgn_a;
	logic     sgn_b;
	al_man_t  skip_man; // Small exponent mantissa, unshifted

	modport src (
		output valid, op, lhs, rhs, add_sub,
		output exp_a, exp_b, a_ge_b, sgn_a, sgn_b, skip_man
	);
	modport sink (
		input valid, op, lhs, rhs, add_sub,
		input exp_a, exp_b, a_ge_b, sgn_a, sgn_b, skip_man
	);
endinterface

// Booth partial sums, only meaningful for OP_MUL
interface pp_if import alu_op_pkg::*; ();
	psum0_t psum0;
	psum1_t psum1;
	logic   s2;   // Negation carry of row 2, lands in row 3

	modport src  (output psum0, psum1, s2);
	modport sink (input  psum0, psum1, s2);
endinterface

// Adder result with everything the output stage needs
interface sum_if import fp_format_pkg::*, alu_op_pkg::*; ();
	logic     valid;
	alu_op_e  op;
	al_sum_t  sum;      // Bit 22 zero for a multiply
	al_exp_t  exp_a;
	al_exp_t  exp_b;
	logic     a_ge_b;
	logic     add_sub;
	logic     sgn_a;
	logic     sgn_b;
	al_man_t  skip_man;

	modport src (
		output valid, op, sum, exp_a, exp_b, a_ge_b,
		output add_sub, sgn_a, sgn_b, skip_man
	);
	modport sink (
		input valid, op, sum, exp_a, exp_b, a_ge_b,
		input add_sub, sgn_a, sgn_b, skip_man
	);
endinterface

`default_nettype wire

// File: source/add_align_stage.sv
// ####################
// FP29i operand alignment
// Exponent compare and swap, then right shift of the
// small side, subtract inversion and zero skip
// ####################
`timescale 1ns/1ps
`default_nettype none

module add_align_stage import fp_format_pkg::*, alu_op_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic in_valid,
	input  alu_op_e   op,
	input  wire logic a_sgn,
	input  al_exp_t   a_exp,
	input  al_man_t   a_man,
	input  wire logic b_sgn,
	input  al_exp_t   b_exp,
	input  al_man_t   b_man,
	align_if.src      align
);

	// Stage 1
	logic [AL_EXP_W:0] exp_diff;     // One extra bit for the borrow
	logic              a_lt_b;
	al_exp_t           exp_diff_abs;
	al_man_t           man_lhs;
	al_man_t           man_rhs;
	al_exp_t           exp_a_in;
	al_exp_t           exp_b_in;

	// Stage 2 registers
	logic              s2_valid;
	alu_op_e           s2_op;
	al_man_t           s2_lhs;
	al_man_t           s2_rhs;
	al_exp_t           s2_shamt;
	logic              s2_a_ge_b;
	logic              s2_add_sub;
	al_exp_t           s2_exp_a;
	al_exp_t           s2_exp_b;
	logic              s2_sgn_a;
	logic              s2_sgn_b;

	// Stage 2 logic
	al_man_t           rhs_aligned;
	logic              lhs_zero;

	assign exp_diff     = {1'b0, a_exp} - {1'b0, b_exp};
	assign a_lt_b       = exp_diff[AL_EXP_W];   // Borrow out
	assign exp_diff_abs = a_lt_b ? (~exp_diff[AL_EXP_W-1:0] + 1'b1) : exp_diff[AL_EXP_W-1:0];

	// Larger exponent goes left, the other one gets shifted
	assign man_lhs = a_lt_b ? b_man : a_man;
	assign man_rhs = a_lt_b ? a_man : b_man;

	// FP16 exponent lives in the low 5 bits
	assign exp_a_in = (op == OP_MUL) ? {1'b0, a_exp[ML_EXP_W-1:0]} : a_exp;
	assign exp_b_in = (op == OP_MUL) ? {1'b0, b_exp[ML_EXP_W-1:0]} : b_exp;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			s2_valid <= 1'b0;
		else
			s2_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		s2_op      <= op;
		s2_lhs     <= man_lhs;
		s2_rhs     <= man_rhs;
		s2_shamt   <= exp_diff_abs;
		s2_a_ge_b  <= ~a_lt_b;
		s2_add_sub <= ~(a_sgn ^ b_sgn); // Equal signs add
		s2_exp_a   <= exp_a_in;
		s2_exp_b   <= exp_b_in;
		s2_sgn_a   <= a_sgn;
		s2_sgn_b   <= b_sgn;
	end

	// Shifts of 32 and up clear the operand
	assign rhs_aligned = s2_shamt[AL_EXP_W-1] ? '0 : (s2_rhs >> s2_shamt[AL_EXP_W-2:0]);
	assign lhs_zero    = (s2_lhs == '0);

	assign align.valid    = s2_valid;
	assign align.op       = (s2_op == OP_ADD && lhs_zero) ? OP_SKIP : s2_op;
	assign align.lhs      = {1'b0, s2_lhs};
	assign align.rhs      = s2_add_sub ? {1'b0, rhs_aligned} : ~{1'b0, rhs_aligned}; // +1 later
	assign align.add_sub  = s2_add_sub;
	assign align.exp_a    = s2_exp_a;
	assign align.exp_b    = s2_exp_b;
	assign align.a_ge_b   = s2_a_ge_b;
	assign align.sgn_a    = s2_sgn_a;
	assign align.sgn_b    = s2_sgn_b;
	assign align.skip_man = s2_rhs;      // Small side passes through untouched

endmodule

`default_nettype wire

// File: source/booth_mul_stage.sv
// ####################
// FP16 mantissa multiplier front end
// Radix-4 Booth partial products, then two
// sign-extended partial sums
// ####################
`timescale 1ns/1ps
`default_nettype none

module booth_mul_stage import fp_format_pkg::*, alu_op_pkg::*; (
	input  wire logic clk,
	input  alu_op_e   op,
	input  al_exp_t   a_exp,
	input  al_man_t   a_man,
	input  al_exp_t   b_exp,
	input  al_man_t   b_man,
	pp_if.src         pp
);

	// Stage 1
	ml_man_t                  man_a;     // Multiplicand
	ml_man_t                  man_b;     // Multiplier, Booth recoded
	logic [ML_MAN_W+2:0]      enc_in;    // Zero pad on top, implicit 0 below
	pp_t                      pp_d [PP_COUNT];
	logic [PP_COUNT-2:0]      neg_d;     // Top group is never negative

	// Stage 2
	pp_t                      pp_q [PP_COUNT];
	logic [PP_COUNT-2:0]      neg_q;
	psum0_t                   ps0;
	psum1_t                   ps1;

	// One Booth digit applied to the multiplicand, inverted when negative
	function automatic pp_t booth_pp(ml_man_t m, logic [2:0] grp);
		logic one;
		logic two;
		pp_t  mag;
		one = grp[1] ^ grp[0];                                        // +/-1
		two = (grp[2] & ~grp[1] & ~grp[0]) | (~grp[2] & grp[1] & grp[0]); // +/-2
		if (one)
			mag = {1'b0, m};
		else if (two)
			mag = {m, 1'b0};
		else
			mag = '0;
		return grp[2] ? ~mag : mag;
	endfunction

	// Hidden 1 for normal numbers, denormals scaled by 2
	assign man_a = (a_exp[ML_EXP_W-1:0] != '0) ? {1'b1, a_man[ML_MAN_W-2:0]}
	                                           : {a_man[ML_MAN_W-2:0], 1'b0};
	assign man_b = (b_exp[ML_EXP_W-1:0] != '0) ? {1'b1, b_man[ML_MAN_W-2:0]}
	                                           : {b_man[ML_MAN_W-2:0], 1'b0};

	assign enc_in = {2'b00, man_b, 1'b0};

	always_comb begin
		for (int i = 0; i < PP_COUNT; i++) begin
			pp_d[i] = booth_pp(man_a, enc_in[2*i +: 3]);
		end
		for (int i = 0; i < PP_COUNT - 1; i++) begin
			neg_d[i] = enc_in[2*i+2];  // Sign carried into the next row
		end
	end

	// Only loaded for a multiply, keeps the tree quiet on adds
	always_ff @(posedge clk) begin
		if (op == OP_MUL) begin
			pp_q  <= pp_d;
			neg_q <= neg_d;
		end
	end

	// Rows 0..2, first row gets the full sign extension
	always_comb begin
		ps0 = {4'b0, ~neg_q[0], neg_q[0], neg_q[0], pp_q[0]};
		ps0 = ps0 + {4'b0001, ~neg_q[1], pp_q[1], 1'b0, neg_q[0]};
		ps0 = ps0 + {2'b01, ~neg_q[2], pp_q[2], 1'b0, neg_q[1], 2'b0};
		// Rows 3..5, offset by 6 bits in the adder
		ps1 = {3'b001, ~neg_q[3], pp_q[3]};
		ps1 = ps1 + {1'b1, ~neg_q[4], pp_q[4], 1'b0, neg_q[3]};
		ps1 = ps1 + {pp_q[5], 1'b0, neg_q[4], 2'b0};
	end

	assign pp.psum0 = ps0;
	assign pp.psum1 = ps1;
	assign pp.s2    = neg_q[2];     // Row 2 carry, too high for psum0

endmodule

`default_nettype wire

// File: source/cla_sum_stage.sv
// ####################
// Shared adder stage
// Picks add or multiply operands, 23b carry-lookahead sum
// ####################
`timescale 1ns/1ps
`default_nettype none

module cla_sum_stage import fp_format_pkg::*, alu_op_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	align_if.sink     align,
	pp_if.sink        pp,
	sum_if.src        sum
);

	localparam int GRP_W = 4;
	localparam int GRP_N = 6;        // 24b, one pad bit over the sum word

	logic     s3_valid;
	alu_op_e  s3_op;
	al_sum_t  s3_lhs;
	al_sum_t  s3_rhs;
	logic     s3_add_sub;
	psum0_t   s3_psum0;
	psum1_t   s3_psum1;
	logic     s3_s2;

	al_sum_t                  add_l;
	al_sum_t                  add_r;
	logic                     add_cin;
	logic [GRP_N*GRP_W-1:0]   gen;
	logic [GRP_N*GRP_W-1:0]   prop;
	logic [GRP_N*GRP_W-1:0]   carry;
	logic [GRP_N:0]           gcarry;   // Carry into each group
	logic [GRP_N*GRP_W-1:0]   sum_full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			s3_valid <= 1'b0;
		else
			s3_valid <= align.valid;
	end

	always_ff @(posedge clk) begin
		s3_op          <= align.op;
		s3_lhs         <= align.lhs;
		s3_rhs         <= align.rhs;
		s3_add_sub     <= align.add_sub;
		s3_psum0       <= pp.psum0;
		s3_psum1       <= pp.psum1;
		s3_s2          <= pp.s2;
		sum.exp_a      <= align.exp_a;
		sum.exp_b      <= align.exp_b;
		sum.a_ge_b     <= align.a_ge_b;
		sum.sgn_a      <= align.sgn_a;
		sum.sgn_b      <= align.sgn_b;
		sum.skip_man   <= align.skip_man;
	end

	// Operand mux, skip leaves the adder idle
	always_comb begin
		case (s3_op)
			OP_ADD: begin
				add_l   = s3_lhs;
				add_r   = s3_rhs;
				add_cin = ~s3_add_sub;         // Two's complement +1
			end
			OP_MUL: begin
				add_l   = {4'b0, s3_psum0};
				add_r   = {1'b0, s3_psum1, 1'b0, s3_s2, 4'b0};
				add_cin = 1'b0;
			end
			default: begin
				add_l   = '0;
				add_r   = '0;
				add_cin = 1'b0;
			end
		endcase
	end

	assign gen       = {1'b0, add_l} & {1'b0, add_r};
	assign prop      = {1'b0, add_l} ^ {1'b0, add_r};
	assign gcarry[0] = add_cin;

	// Lookahead inside each 4b group, group carries chained by G/P
	for (genvar g = 0; g < GRP_N; g++) begin : g_grp
		logic [GRP_W-1:0] gg;
		logic [GRP_W-1:0] pg;
		logic             c0;
		assign gg = gen[GRP_W*g +: GRP_W];
		assign pg = prop[GRP_W*g +: GRP_W];
		assign c0 = gcarry[g];
		assign carry[GRP_W*g]   = c0;
		assign carry[GRP_W*g+1] = gg[0] | (pg[0] & c0);
		assign carry[GRP_W*g+2] = gg[1] | (pg[1] & gg[0]) | (pg[1] & pg[0] & c0);
		assign carry[GRP_W*g+3] = gg[2] | (pg[2] & gg[1]) | (pg[2] & pg[1] & gg[0])
		                        | (pg[2] & pg[1] & pg[0] & c0);
		assign gcarry[g+1] = gg[3] | (pg[3] & gg[2]) | (pg[3] & pg[2] & gg[1])
		                   | (pg[3] & pg[2] & pg[1] & gg[0])
		                   | (&pg & c0);
	end

	assign sum_full = prop ^ carry;

	assign sum.valid   = s3_valid;
	assign sum.op      = s3_op;
	assign sum.add_sub = s3_add_sub;
	// Product is 22b, drop the sign-extension wrap above it
	assign sum.sum = (s3_op == OP_MUL) ? {1'b0, sum_full[AL_SUM_W-2:0]}
	                                   : sum_full[AL_SUM_W-1:0];

endmodule

`default_nettype wire

// File: source/norm_out_stage.sv
// ####################
// Output normalizer
// Leading-zero count, left shift so that bit 21 is set,
// exponent adjust and result sign
// ####################
`timescale 1ns/1ps
`default_nettype none

module norm_out_stage import fp_format_pkg::*, alu_op_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	sum_if.sink       sum,
	output logic      out_valid,
	output logic      y_sgn,
	output al_exp_t   y_exp,
	output al_man_t   y_man
);

	localparam int EXP_X_W = AL_EXP_W + 2;   // Headroom for the rebias math
	// Product rebias: +AL bias -2x ML bias, +1 for the 2^20 scale, +1 for normalization
	localparam logic [EXP_X_W-1:0] MUL_EXP_OFS = EXP_X_W'(AL_EXP_BIAS + 2 - 2 * ML_EXP_BIAS);

	// Stage 4
	logic                s4_valid;
	alu_op_e             s4_op;
	al_sum_t             s4_sum;
	al_exp_t             s4_exp_a;
	al_exp_t             s4_exp_b;
	logic                s4_a_ge_b;
	logic                s4_add_sub;
	logic                s4_sgn_a;
	logic                s4_sgn_b;
	al_man_t             s4_skip_man;
	lz_cnt_t             s4_lz;
	logic [EXP_X_W-1:0]  s4_exp_base;
	logic                s4_sgn;

	// Stage 5
	logic                s5_valid;
	alu_op_e             s5_op;
	al_sum_t             s5_sum;
	lz_cnt_t             s5_lz;
	logic [EXP_X_W-1:0]  s5_exp_base;
	logic                s5_sgn;
	al_man_t             s5_skip_man;
	al_sum_t             s5_shifted;
	logic [EXP_X_W-1:0]  s5_exp_adj;

	// Position of the top set bit, 23 for an all-zero word
	function automatic lz_cnt_t lead_zeros(al_sum_t v);
		lz_cnt_t cnt;
		cnt = lz_cnt_t'(AL_SUM_W);
		for (int i = 0; i < AL_SUM_W; i++) begin
			if (v[i])
				cnt = lz_cnt_t'(AL_SUM_W - 1 - i);
		end
		return cnt;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s4_valid <= 1'b0;
			s5_valid <= 1'b0;
		end else begin
			s4_valid <= sum.valid;
			s5_valid <= s4_valid;
		end
	end

	always_ff @(posedge clk) begin
		s4_op       <= sum.op;
		s4_sum      <= sum.sum;
		s4_exp_a    <= sum.exp_a;
		s4_exp_b    <= sum.exp_b;
		s4_a_ge_b   <= sum.a_ge_b;
		s4_add_sub  <= sum.add_sub;
		s4_sgn_a    <= sum.sgn_a;
		s4_sgn_b    <= sum.sgn_b;
		s4_skip_man <= sum.skip_man;
	end

	// LZD plus the exponent before the shift correction
	always_comb begin
		s4_lz = lead_zeros(s4_sum);
		case (s4_op)
			OP_MUL: begin
				s4_exp_base = {2'b0, s4_exp_a} + {2'b0, s4_exp_b} + MUL_EXP_OFS;
				s4_sgn      = s4_sgn_a ^ s4_sgn_b;
			end
			OP_SKIP: begin                        // Small exponent side survives
				s4_exp_base = s4_a_ge_b ? {2'b0, s4_exp_b} : {2'b0, s4_exp_a};
				s4_sgn      = s4_a_ge_b ? s4_sgn_b : s4_sgn_a;
			end
			default: begin
				s4_exp_base = (s4_a_ge_b ? {2'b0, s4_exp_a} : {2'b0, s4_exp_b}) + 1'b1;
				s4_sgn      = s4_add_sub ? s4_sgn_a : (s4_a_ge_b ? s4_sgn_a : s4_sgn_b);
			end
		endcase
	end

	always_ff @(posedge clk) begin
		s5_op       <= s4_op;
		s5_sum      <= s4_sum;
		s5_lz       <= s4_lz;
		s5_exp_base <= s4_exp_base;
		s5_sgn      <= s4_sgn;
		s5_skip_man <= s4_skip_man;
	end

	assign s5_shifted = s5_sum << s5_lz;                      // MSB lands on bit 22
	assign s5_exp_adj = s5_exp_base - {{(EXP_X_W-LZ_CNT_W){1'b0}}, s5_lz};

	always_comb begin
		if (s5_op == OP_SKIP) begin
			y_man = s5_skip_man;
			y_exp = s5_exp_base[AL_EXP_W-1:0];
			y_sgn = s5_sgn;
		end else if (s5_sum == '0) begin                      // Clean zero
			y_man = '0;
			y_exp = '0;
			y_sgn = 1'b0;
		end else begin
			y_man = s5_shifted[AL_SUM_W-1:1];                 // Truncate the guard bit
			y_exp = s5_exp_adj[AL_EXP_W-1:0];                 // Overflow not handled
			y_sgn = s5_sgn;
		end
	end

	assign out_valid = s5_valid;

endmodule

`default_nettype wire

// File: source/fp_alu_top.sv
// ####################
// FP ALU top level
// Five-stage pipe, FP29i add/sub and FP16 multiply,
// result four edges after the operand is taken
// ####################
`timescale 1ns/1ps
`default_nettype none

module fp_alu_top import fp_format_pkg::*, alu_op_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire logic    in_valid,
	input  alu_op_e      op,
	input  wire logic    a_sgn,
	input  al_exp_t      a_exp,  // FP16 uses bits 4:0
	input  al_man_t      a_man,  // FP16 uses bits 9:0
	input  wire logic    b_sgn,
	input  al_exp_t      b_exp,
	input  al_man_t      b_man,
	output logic         out_valid,
	output logic         y_sgn,
	output al_exp_t      y_exp,
	output al_man_t      y_man
);

	align_if i_align_if ();
	pp_if    i_pp_if ();
	sum_if   i_sum_if ();

	// Stages 1-2, add path
	add_align_stage i_add_align_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.op       (op),
		.a_sgn    (a_sgn),
		.a_exp    (a_exp),
		.a_man    (a_man),
		.b_sgn    (b_sgn),
		.b_exp    (b_exp),
		.b_man    (b_man),
		.align    (i_align_if.src)
	);

	// Stages 1-2, multiply path
	booth_mul_stage i_booth_mul_stage (
		.clk   (clk),
		.op    (op),
		.a_exp (a_exp),
		.a_man (a_man),
		.b_exp (b_exp),
		.b_man (b_man),
		.pp    (i_pp_if.src)
	);

	// Stage 3, shared adder
	cla_sum_stage i_cla_sum_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.align (i_align_if.sink),
		.pp    (i_pp_if.sink),
		.sum   (i_sum_if.src)
	);

	// Stages 4-5, normalize and drive out
	norm_out_stage i_norm_out_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.sum       (i_sum_if.sink),
		.out_valid (out_valid),
		.y_sgn     (y_sgn),
		.y_exp     (y_exp),
		.y_man     (y_man)
	);

endmodule

`default_nettype wire

// File: verif/clk_rst_gen.sv
// ####################
// Test clock and reset
// 40 ns clock, rst_n low for the first 4 rising edges
// ####################
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 20;  // ns
	localparam int RST_CYCLES  = 4;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;                    // Released on a rising edge
	end

endmodule

`default_nettype wire

// File: verif/tb_fp_alu.sv
// ####################
// FP ALU testbench
// Replays the stimulus file with random idle gaps,
// checks every result and its latency
// ####################
`timescale 1ns/1ps
`default_nettype none

module tb_fp_alu import fp_format_pkg::*, alu_op_pkg::*; ();

	localparam int    CLK_PERIOD = 40;    // ns, same as clk_rst_gen
	localparam int    LATENCY    = 4;     // Edges from issue to out_valid
	localparam int    MAX_GAP    = 2;     // Idle cycles between operations
	localparam string STIM_FILE  = "verif/fp_alu_stim.txt";

	typedef struct {
		alu_op_e op;
		logic    a_sgn;
		al_exp_t a_exp;
		al_man_t a_man;
		logic    b_sgn;
		al_exp_t b_exp;
		al_man_t b_man;
		logic    y_sgn;
		al_exp_t y_exp;
		al_man_t y_man;
	} stim_t;

	typedef struct {
		int      idx;
		int      due;    // Edge count when out_valid must be seen
		logic    y_sgn;
		al_exp_t y_exp;
		al_man_t y_man;
	} result_t;

	logic    clk;
	logic    rst_n;
	logic    in_valid;
	alu_op_e op;
	logic    a_sgn;
	al_exp_t a_exp;
	al_man_t a_man;
	logic    b_sgn;
	al_exp_t b_exp;
	al_man_t b_man;
	logic    out_valid;
	logic    y_sgn;
	al_exp_t y_exp;
	al_man_t y_man;

	stim_t       stim_q [$];
	result_t     pend_q [$];
	int          n_done    = 0;
	int          cyc       = 0;          // Rising edges so far
	logic        loaded    = 1'b0;
	logic [31:0] lcg_state = 32'hac2c46af;

	clk_rst_gen i_clk_rst_gen (.clk(clk), .rst_n(rst_n));

	fp_alu_top i_fp_alu_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a_sgn     (a_sgn),
		.a_exp     (a_exp),
		.a_man     (a_man),
		.b_sgn     (b_sgn),
		.b_exp     (b_exp),
		.b_man     (b_man),
		.out_valid (out_valid),
		.y_sgn     (y_sgn),
		.y_exp     (y_exp),
		.y_man     (y_man)
	);

	always @(posedge clk) cyc <= cyc + 1;

	// Numerical Recipes LCG constants
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "first mismatch");
	endtask

	task automatic check_man(input int idx, input al_man_t got, input al_man_t want);
		if (got !== want)
			report_error($sformatf("op %0d y_man is %h, expected %h", idx, got, want));
	endtask

	task automatic check_exp(input int idx, input al_exp_t got, input al_exp_t want);
		if (got !== want)
			report_error($sformatf("op %0d y_exp is %h, expected %h", idx, got, want));
	endtask

	task automatic check_sgn(input int idx, input logic got, input logic want);
		if (got !== want)
			report_error($sformatf("op %0d y_sgn is %b, expected %b", idx, got, want));
	endtask

	// Comment lines start with //, ten hex fields otherwise
	task automatic load_stimulus();
		int          fd;
		int          code;
		string       line;
		logic [31:0] f [10];
		stim_t       s;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file %s", STIM_FILE);
			$display("Simulation failed");
			$fatal(1, "no stimulus");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() < 2 || line.substr(0, 1) == "//")
					continue;
				code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
				               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
				if (code != 10) begin
					$display("Stimulus line does not hold ten fields: %s", line);
					$display("Simulation failed");
					$fatal(1, "bad stimulus");
				end else begin
					s.op    = alu_op_e'(f[0][1:0]);
					s.a_sgn = f[1][0];
					s.a_exp = al_exp_t'(f[2]);
					s.a_man = al_man_t'(f[3]);
					s.b_sgn = f[4][0];
					s.b_exp = al_exp_t'(f[5]);
					s.b_man = al_man_t'(f[6]);
					s.y_sgn = f[7][0];
					s.y_exp = al_exp_t'(f[8]);
					s.y_man = al_man_t'(f[9]);
					stim_q.push_back(s);
				end
			end
			$fclose(fd);
		end
	endtask

	// Random idle cycles, then one operation for a single clock
	task automatic drive_op(input int idx);
		int      gap;
		result_t r;
		gap = int'(next_random() >> 16) % (MAX_GAP + 1);
		repeat (gap) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
		@(posedge clk);
		in_valid <= 1'b1;
		op       <= stim_q[idx].op;
		a_sgn    <= stim_q[idx].a_sgn;
		a_exp    <= stim_q[idx].a_exp;
		a_man    <= stim_q[idx].a_man;
		b_sgn    <= stim_q[idx].b_sgn;
		b_exp    <= stim_q[idx].b_exp;
		b_man    <= stim_q[idx].b_man;
		r.idx    = idx;
		r.due    = cyc + 1 + LATENCY;   // cyc still holds the previous edge
		r.y_sgn  = stim_q[idx].y_sgn;
		r.y_exp  = stim_q[idx].y_exp;
		r.y_man  = stim_q[idx].y_man;
		pend_q.push_back(r);
	endtask

	initial begin
		in_valid = 1'b0;
		op       = OP_ADD;
		a_sgn    = 1'b0;
		a_exp    = '0;
		a_man    = '0;
		b_sgn    = 1'b0;
		b_exp    = '0;
		b_man    = '0;
		load_stimulus();
		loaded = 1'b1;
		wait (rst_n === 1'b1);
		foreach (stim_q[i]) begin
			drive_op(i);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (pend_q.size() != 0)
			@(posedge clk);
		repeat (LATENCY) @(posedge clk);   // Nothing may trail the last result
		if (n_done > 0 && n_done == stim_q.size()) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Only %0d of %0d results arrived", n_done, stim_q.size());
			$display("Simulation failed");
			$fatal(1, "missing results");
		end
	end

	// Outputs settle between edges, sampled on the falling one
	always @(negedge clk) begin : monitor
		result_t r;
		if (rst_n !== 1'b1) begin
			if (out_valid !== 1'b0)
				report_error("out_valid not low during reset");
		end else if (out_valid === 1'b1) begin
			if (pend_q.size() == 0)
				report_error("out_valid high with no operation pending");
			r = pend_q.pop_front();
			if (r.due != cyc)
				report_error($sformatf("op %0d came at edge %0d, due at %0d", r.idx, cyc, r.due));
			check_sgn(r.idx, y_sgn, r.y_sgn);
			check_exp(r.idx, y_exp, r.y_exp);
			check_man(r.idx, y_man, r.y_man);
			n_done++;
		end else if (out_valid !== 1'b0) begin
			report_error("out_valid is unknown");
		end else if (pend_q.size() != 0 && pend_q[0].due == cyc) begin
			report_error($sformatf("op %0d missing, out_valid low", pend_q[0].idx));
		end
	end

	// Worst case every operation takes MAX_GAP idle cycles
	initial begin
		wait (loaded);
		#((stim_q.size() * (MAX_GAP + 1) + 20) * CLK_PERIOD);
		$display("Timeout: results still missing after %0d ns", $time);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: fp_alu.f
source/fp_format_pkg.sv
source/alu_op_pkg.sv
source/fp_alu_if.sv
source/add_align_stage.sv
source/booth_mul_stage.sv
source/cla_sum_stage.sv
source/norm_out_stage.sv
source/fp_alu_top.sv
verif/clk_rst_gen.sv
verif/tb_fp_alu.sv

// File: verif/fp_alu_stim.txt
// op a_sgn a_exp a_man b_sgn b_exp b_man, then expected y_sgn y_exp y_man, all hex
// op 3 is FP29i add/sub, op 2 is FP16 multiply using exponent 4:0 and fraction 9:0
3 0 22 300000 0 20 280000 0 22 3A0000
3 1 10 3FFFFF 1 13 200001 1 13 280000
3 0 30 212345 0 05 3FFFFF 0 30 212345
3 0 20 001000 0 1F 000800 0 17 280000
3 0 20 300000 1 1F 200000 0 20 200000
3 0 18 2C0000 1 1A 240000 1 19 320000
3 1 25 3ABCDE 0 25 1234AB 1 25 288833
3 0 10 155555 1 10 155555 0 00 000000
3 1 21 200000 0 1E 3FFFFF 1 20 300002
3 0 28 000000 1 10 0ABCDE 1 10 0ABCDE
3 1 05 123456 0 06 000000 1 05 123456
2 0 0F 000000 0 0F 000000 0 1F 200000
2 1 30 3FFE00 0 11 000300 1 23 2A0000
2 1 0A 0003FF 1 14 0003FF 0 20 3FF001
2 0 00 000155 0 0F 0000AB 0 0F 31BE38
2 1 00 000001 0 1E 0003FF 1 16 3FF800
2 0 00 000000 1 0F 000123 0 00 000000
